// ==== all.f ====
+incdir+.
pkt_pkg.sv
pkt_frame_check.sv
pkt_drop_fifo.sv
pkt_out_reg.sv
pkt_filter_top.sv
tb_pkt_filter.sv

// ==== Bender.yml ====
package:
  name: pkt_filter

export_include_dirs:
  - .

sources:
  - pkt_pkg.sv
  - pkt_frame_check.sv
  - pkt_drop_fifo.sv
  - pkt_out_reg.sv
  - pkt_filter_top.sv
  - target: test
    files:
      - tb_pkt_filter.sv

// ==== tb_pkt_filter.sv ====
// Packet filter testbench
// Random good and corrupted packets, with and without back-pressure,
// compared against a reference model of the packet format

`timescale 1ns/100ps
`default_nettype none

`include "pkt_params.svh"

module tb_pkt_filter
  import pkt_pkg::*;
();

  localparam int KIND_GOOD    = 0;
  localparam int KIND_BAD_SUM = 1;
  localparam int KIND_BAD_LEN = 2;
  localparam int KIND_RANGE   = 3;
  localparam int KIND_ERROR   = 4;

  logic      clk;
  logic      i_arst_n;
  pkt_beat_t i_beat;
  logic      i_valid;
  logic      i_error;
  logic      o_ready;
  pkt_beat_t o_beat;
  logic      o_valid;
  logic      i_ready;
  logic      o_drop;

  integer                 seed;
  integer                 bp_seed;
  logic [`PKT_DATA_W-1:0] pkt_q [$];
  pkt_beat_t              exp_q [$];
  int                     beats_queued;
  int                     bad_tally;
  int                     drop_cnt;
  int                     cycle_cnt;
  bit                     bp_mode;
  bit                     hold_ready;
  bit                     ready_fell;
  bit                     sender_done;
  string                  test_name;
  bit                     stall_q;
  pkt_beat_t              held_beat;
  logic [31:0]            bp_word;

  pkt_filter_top pkt_filter_top_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_beat   (i_beat),
    .i_valid  (i_valid),
    .i_error  (i_error),
    .o_ready  (o_ready),
    .o_beat   (o_beat),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_drop   (o_drop)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
                              test_name, what, expected, actual));
    end
  endtask

  // Reference model of the packet format
  function automatic bit packet_is_good(input bit err);
    int          n;
    int          i;
    int          len;
    logic [31:0] word;
    logic [31:0] acc;
    n    = pkt_q.size();
    word = pkt_q[0];
    len  = word[15:0];
    acc  = '0;
    for (i = 0; i < n - 1; i++) begin
      acc = acc ^ pkt_q[i];
    end
    return (len == n) && (len >= 3) && (len <= `PKT_MAX_BEATS) &&
           (pkt_q[n-1] == acc) && !err;
  endfunction

  // Builds one packet in pkt_q, corrupted as the kind asks
  task automatic build_packet(input int kind, output bit err);
    int          n;
    int          i;
    logic [15:0] len;
    logic [31:0] word;
    logic [31:0] pick;
    logic [31:0] sum;
    n    = 3 + ($unsigned($random(seed)) % (`PKT_MAX_BEATS - 2));
    word = $random(seed);
    pick = $random(seed);
    len  = n;
    if (kind == KIND_BAD_LEN) begin
      len = (n > 3) ? n - 1 : n + 1;
    end else if (kind == KIND_RANGE) begin
      case (pick[1:0])
        2'd0:    len = 16'd0;
        2'd1:    len = 16'd1;
        2'd2:    len = 16'd2;
        default: len = `PKT_MAX_BEATS + 1 + pick[11:4];
      endcase
    end
    pkt_q.delete();
    pkt_q.push_back({word[31:16], len});
    for (i = 1; i < n - 1; i++) begin
      pkt_q.push_back($random(seed));
    end
    sum = '0;
    for (i = 0; i < n - 1; i++) begin
      sum = sum ^ pkt_q[i];
    end
    if (kind == KIND_BAD_SUM) begin
      sum = sum ^ (32'h1 << pick[8:4]);
    end
    pkt_q.push_back(sum);
    err          = (kind == KIND_ERROR);
    beats_queued = beats_queued + n;
  endtask

  task automatic send_packet(input bit err);
    int        i;
    int        n;
    bit        good;
    pkt_beat_t b;
    n    = pkt_q.size();
    good = packet_is_good(err);
    for (i = 0; i < n; i++) begin
      i_beat.data = pkt_q[i];
      i_beat.last = (i == n - 1);
      i_error     = err && (i == n - 1);
      i_valid     = 1'b1;
      @(posedge clk);
      while (!o_ready) @(posedge clk);
      #1;
    end
    i_valid = 1'b0;
    i_error = 1'b0;
    // A packet is only expected once its last beat is in
    if (good) begin
      for (i = 0; i < n; i++) begin
        b.data = pkt_q[i];
        b.last = (i == n - 1);
        exp_q.push_back(b);
      end
    end else begin
      bad_tally = bad_tally + 1;
    end
    @(posedge clk);
    compare_value("drop pulse", !good, o_drop);
    #1;
  endtask

  // Negative kind picks a random kind per packet
  task automatic run_packets(input int count, input int kind);
    int k;
    int pick_kind;
    int gap;
    bit err;
    for (k = 0; k < count; k++) begin
      pick_kind = (kind < 0) ? $unsigned($random(seed)) % 5 : kind;
      build_packet(pick_kind, err);
      send_packet(err);
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Sink ready
  always @(posedge clk) begin
    #1;
    if (hold_ready) begin
      i_ready = 1'b0;
    end else if (bp_mode) begin
      bp_word = $random(bp_seed);
      i_ready = bp_word[0];
    end else begin
      i_ready = 1'b1;
    end
  end

  // Output comparator and stall checks
  always @(posedge clk) begin
    if (i_arst_n) begin
      if (stall_q) begin
        compare_value("held valid", 1, o_valid);
        compare_value("held beat", held_beat, o_beat);
      end
      if (o_valid && i_ready) begin
        if (exp_q.size() == 0) begin
          stop_on_error("Output beat arrived with no complete good packet pending");
        end else begin
          compare_value("output beat", exp_q.pop_front(), o_beat);
        end
      end
      if (o_drop) begin
        drop_cnt = drop_cnt + 1;
      end
      stall_q   = o_valid && !i_ready;
      held_beat = o_beat;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > 1000 + 40 * beats_queued) begin
      stop_on_error("Timeout: the run took longer than its cycle limit");
    end
  end

  initial begin
    seed         = 32'hbb4c;
    bp_seed      = seed ^ 32'h5a5a_0f0f;
    clk          = 1'b0;
    i_arst_n     = 1'b0;
    i_beat       = '0;
    i_valid      = 1'b0;
    i_error      = 1'b0;
    i_ready      = 1'b1;
    bp_mode      = 1'b0;
    hold_ready   = 1'b0;
    ready_fell   = 1'b0;
    sender_done  = 1'b0;
    stall_q      = 1'b0;
    held_beat    = '0;
    beats_queued = 0;
    bad_tally    = 0;
    drop_cnt     = 0;
    cycle_cnt    = 0;
    test_name    = "reset";
    repeat (10) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    compare_value("o_valid", 0, o_valid);
    compare_value("o_drop", 0, o_drop);
    compare_value("o_ready", 1, o_ready);
    compare_value("checker state", CHK_HEADER, pkt_filter_top_i.pkt_frame_check_i.state);

    test_name = "good_stream";
    run_packets(20, KIND_GOOD);
    test_name = "bad_mix";
    run_packets(30, -1);
    test_name = "error_strobe";
    run_packets(1, KIND_GOOD);
    run_packets(1, KIND_ERROR);
    run_packets(1, KIND_GOOD);
    test_name = "random_backpressure";
    bp_mode   = 1'b1;
    run_packets(40, -1);
    run_packets(10, KIND_GOOD);

    // Sink stalls until the input side backs up
    test_name  = "hold_ready";
    bp_mode    = 1'b0;
    hold_ready = 1'b1;
    fork
      begin
        run_packets(8, KIND_GOOD);
        sender_done = 1'b1;
      end
      begin
        while (!ready_fell && !sender_done) begin
          @(posedge clk);
          if (!o_ready) ready_fell = 1'b1;
        end
        repeat (20) @(posedge clk);
        #1;
        hold_ready = 1'b0;
      end
    join
    compare_value("o_ready fell", 1, ready_fell);

    while (exp_q.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    test_name = "summary";
    compare_value("drop count", bad_tally, drop_cnt);
    compare_value("idle o_valid", 0, o_valid);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pkt_filter_top.sv ====
// Packet filter top
// Frame checker feeding the dropping FIFO, then the output register

`timescale 1ns/100ps
`default_nettype none

module pkt_filter_top
  import pkt_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_arst_n,
  input  wire pkt_beat_t i_beat,
  input  wire logic      i_valid,
  input  wire logic      i_error,
  output logic           o_ready,
  output pkt_beat_t      o_beat,
  output logic           o_valid,
  input  wire logic      i_ready,
  output logic           o_drop
);

  pkt_beat_t chk_beat;
  logic      chk_valid;
  logic      chk_bad;
  logic      fifo_ready;
  pkt_beat_t fifo_beat;
  logic      fifo_valid;
  logic      oreg_ready;

  assign o_ready = fifo_ready;

  pkt_frame_check pkt_frame_check_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_beat   (i_beat),
    .i_valid  (i_valid),
    .i_error  (i_error),
    .i_ready  (fifo_ready),
    .o_beat   (chk_beat),
    .o_valid  (chk_valid),
    .o_bad    (chk_bad)
  );

  pkt_drop_fifo pkt_drop_fifo_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_beat   (chk_beat),
    .i_valid  (chk_valid),
    .i_bad    (chk_bad),
    .o_ready  (fifo_ready),
    .o_beat   (fifo_beat),
    .o_valid  (fifo_valid),
    .i_ready  (oreg_ready),
    .o_drop   (o_drop)
  );

  pkt_out_reg pkt_out_reg_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_beat   (fifo_beat),
    .i_valid  (fifo_valid),
    .o_ready  (oreg_ready),
    .o_beat   (o_beat),
    .o_valid  (o_valid),
    .i_ready  (i_ready)
  );

endmodule

`default_nettype wire

// ==== pkt_out_reg.sv ====
// Output register stage
// Main and skid entries give full throughput while the ready toward
// the FIFO comes from local flops only

`timescale 1ns/100ps
`default_nettype none

module pkt_out_reg
  import pkt_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_arst_n,
  input  wire pkt_beat_t i_beat,
  input  wire logic      i_valid,
  output logic           o_ready,
  output pkt_beat_t      o_beat,
  output logic           o_valid,
  input  wire logic      i_ready
);

  pkt_beat_t skid_beat;
  logic      skid_valid;
  logic      in_xfer;
  logic      main_free;

  assign o_ready   = ~skid_valid;
  assign in_xfer   = i_valid & o_ready;
  assign main_free = ~o_valid | i_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // Skid entry drains first, the input is stalled meanwhile
      o_valid    <= skid_valid | in_xfer;
      skid_valid <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      o_beat <= skid_valid ? skid_beat : i_beat;
    end
    if (!main_free && in_xfer) begin
      skid_beat <= i_beat;
    end
  end

  // A stalled output beat holds until the sink takes it
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_beat))
  );

endmodule

`default_nettype wire

// ==== pkt_drop_fifo.sv ====
// Dropping packet FIFO
// Stores whole packets, rewinds the write pointer over a flagged packet
// and only releases packets that are completely stored

`timescale 1ns/100ps
`default_nettype none

`include "pkt_params.svh"

module pkt_drop_fifo
  import pkt_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_arst_n,
  input  wire pkt_beat_t i_beat,
  input  wire logic      i_valid,
  input  wire logic      i_bad,
  output logic           o_ready,
  output pkt_beat_t      o_beat,
  output logic           o_valid,
  input  wire logic      i_ready,
  output logic           o_drop
);

  localparam int AW = `PKT_FIFO_AW;
  localparam logic [AW:0] DEPTH = (AW+1)'(1) << AW;

  pkt_beat_t mem [2**AW];

  // Pointers carry one wrap bit above the address
  logic [AW:0]   wr_ptr;
  logic [AW:0]   good_end;
  logic [AW:0]   rd_ptr;
  logic [AW-1:0] pkt_wr_cnt;
  logic [AW-1:0] pkt_rd_cnt;

  logic [AW:0]   occ;
  logic [AW:0]   good_occ;
  logic          full;
  logic          empty;
  logic          wr_en;
  logic          wr_last;
  logic          rd_en;
  logic          rd_fresh;
  logic          last_issued;
  logic [AW-1:0] rd_cnt_now;
  logic          pkt_avail;

  assign occ      = wr_ptr - rd_ptr;
  assign good_occ = good_end - rd_ptr;
  assign full     = (occ == DEPTH);
  assign empty    = (occ == '0);

  assign o_ready = ~full;
  assign wr_en   = i_valid & o_ready;
  assign wr_last = wr_en & i_beat.last;

  // Write side
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr     <= '0;
      good_end   <= '0;
      pkt_wr_cnt <= '0;
      o_drop     <= 1'b0;
    end else begin
      o_drop <= wr_last & i_bad;
      if (wr_last) begin
        if (i_bad) begin
          // Forget everything written since the last good packet
          wr_ptr <= good_end;
        end else begin
          wr_ptr     <= wr_ptr + (AW+1)'(1);
          good_end   <= wr_ptr + (AW+1)'(1);
          pkt_wr_cnt <= pkt_wr_cnt + AW'(1);
        end
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + (AW+1)'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= i_beat;
    end
  end

  // The beat read on the previous edge is only seen now, so a last beat
  // counts as read one cycle after it left memory
  assign last_issued = rd_fresh & o_beat.last;
  assign rd_cnt_now  = pkt_rd_cnt + {{(AW-1){1'b0}}, last_issued};
  assign pkt_avail   = (pkt_wr_cnt != rd_cnt_now);
  assign rd_en       = ~empty & pkt_avail & (~o_valid | i_ready);

  // Read side
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_ptr     <= '0;
      pkt_rd_cnt <= '0;
      rd_fresh   <= 1'b0;
      o_valid    <= 1'b0;
    end else begin
      rd_fresh   <= rd_en;
      pkt_rd_cnt <= rd_cnt_now;
      if (rd_en) begin
        rd_ptr <= rd_ptr + (AW+1)'(1);
      end
      if (~o_valid | i_ready) begin
        o_valid <= rd_en;
      end
    end
  end

  // Registered memory output
  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_beat <= mem[rd_ptr[AW-1:0]];
    end
  end

  // Occupancy never goes past the memory size
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    occ <= DEPTH
  );

  // Reads stay behind the end of the last good packet
  a_rd_behind_good : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    good_occ <= occ
  );

endmodule

`default_nettype wire

// ==== pkt_frame_check.sv ====
// Frame checker
// Watches each packet as it passes and flags the last beat of a packet
// with a bad length, a bad checksum or an upstream error

`timescale 1ns/100ps
`default_nettype none

`include "pkt_params.svh"

module pkt_frame_check
  import pkt_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_arst_n,
  input  wire pkt_beat_t i_beat,
  input  wire logic      i_valid,
  input  wire logic      i_error,
  input  wire logic      i_ready,
  output pkt_beat_t      o_beat,
  output logic           o_valid,
  output logic           o_bad
);

  // Length field of the header
  localparam int LEN_W = 16;

  chk_state_e             state;
  logic [LEN_W-1:0]       cnt_q;
  logic [LEN_W-1:0]       len_q;
  logic [`PKT_DATA_W-1:0] xor_q;

  logic                   xfer;
  logic [LEN_W-1:0]       cur_len;
  logic [LEN_W-1:0]       cur_cnt;
  logic [`PKT_DATA_W-1:0] cur_xor;
  logic                   len_bad;
  logic                   sum_bad;

  assign xfer = i_valid & i_ready;

  // A header beat that also carries last is judged against itself
  assign cur_len = (state == CHK_HEADER) ? i_beat.data[LEN_W-1:0] : len_q;
  assign cur_cnt = (state == CHK_HEADER) ? LEN_W'(1) : cnt_q + LEN_W'(1);
  assign cur_xor = (state == CHK_HEADER) ? '0 : xor_q;

  assign len_bad = (cur_cnt != cur_len) || (cur_len < LEN_W'(3)) ||
                   (cur_len > LEN_W'(`PKT_MAX_BEATS));
  assign sum_bad = (i_beat.data != cur_xor);

  // Beats pass through unchanged
  assign o_beat  = i_beat;
  assign o_valid = i_valid;
  assign o_bad   = i_valid & i_beat.last & (len_bad | sum_bad | i_error);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= CHK_HEADER;
      cnt_q <= '0;
    end else if (xfer) begin
      if (i_beat.last) begin
        state <= CHK_HEADER;
        cnt_q <= '0;
      end else begin
        state <= CHK_BODY;
        cnt_q <= cur_cnt;
      end
    end
  end

  // Header length and running checksum
  always_ff @(posedge clk) begin
    if (xfer) begin
      if (state == CHK_HEADER) begin
        len_q <= i_beat.data[LEN_W-1:0];
      end
      xor_q <= cur_xor ^ i_beat.data;
    end
  end

  // A stalled input beat holds until the FIFO takes it
  a_in_hold : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_valid && !i_ready) |=> (i_valid && $stable(i_beat) && $stable(i_error))
  );

endmodule

`default_nettype wire

// ==== pkt_pkg.sv ====
// Packet filter types
// Beat struct shared by every stage, and the frame checker state

`default_nettype none

`include "pkt_params.svh"

package pkt_pkg;

  // One bus beat, also one FIFO entry
  typedef struct packed {
    logic [`PKT_DATA_W-1:0] data;
    logic                   last;
  } pkt_beat_t;

  // Frame checker position inside a packet
  typedef enum logic {
    CHK_HEADER = 1'b0,
    CHK_BODY   = 1'b1
  } chk_state_e;

endpackage

`default_nettype wire

// ==== pkt_params.svh ====
// Packet filter parameters
// Bus width, FIFO size and the largest legal packet

`ifndef PKT_PARAMS_SVH
`define PKT_PARAMS_SVH

// Width of one bus beat's data
`define PKT_DATA_W 32

// FIFO address width, 2**6 = 64 entries
`define PKT_FIFO_AW 6

// Largest legal packet in beats, header and checksum included
`define PKT_MAX_BEATS 63

`endif
